// ==== bench/cacheTb.sv ====
`include "cacheSettings.svh"

module cacheTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int offW       = `CACHE_OFFSET_W;
  localparam int lowW       = `CACHE_INDEX_W + `CACHE_OFFSET_W;
  localparam int resetLimit = 20;

  logic                 clk;
  logic                 rstN;
  cachePkg::cacheReq_t  req;
  cachePkg::cacheLine_t fillLine;
  cachePkg::cacheResp_t resp;
  cachePkg::cacheLine_t evictLine;

  // model of every set the tests touch
  cachePkg::wayTag_t    modelTag  [`CACHE_SETS][`CACHE_WAYS];
  cachePkg::cacheLine_t modelLine [`CACHE_SETS][`CACHE_WAYS];

  int errors      = 0;
  int checks      = 0;
  int testsRun    = 0;
  int testsFailed = 0;

  clockGen clockGen0 (
    .clk  (clk),
    .rstN (rstN)
  );

  dataCache dut0 (
    .clk       (clk),
    .rstN      (rstN),
    .req       (req),
    .fillLine  (fillLine),
    .resp      (resp),
    .evictLine (evictLine)
  );

  task automatic reportMismatch(input string sig, input logic [511:0] expected,
                                input logic [511:0] actual);
    errors++;
    $display("Mismatch at %0d ns: %s expected %0h actual %0h", $time, sig, expected, actual);
  endtask

  task automatic checkResp(input cachePkg::cacheResp_t expected,
                           input cachePkg::cacheResp_t actual);
    checks++;
    if (actual.hit !== expected.hit)
      reportMismatch("resp.hit", expected.hit, actual.hit);
    if (actual.readData !== expected.readData)
      reportMismatch("resp.readData", expected.readData, actual.readData);
    if (actual.evictDirty !== expected.evictDirty)
      reportMismatch("resp.evictDirty", expected.evictDirty, actual.evictDirty);
    if (actual.evictAddr !== expected.evictAddr)
      reportMismatch("resp.evictAddr", expected.evictAddr, actual.evictAddr);
  endtask

  task automatic checkLine(input cachePkg::cacheLine_t expected,
                           input cachePkg::cacheLine_t actual);
    checks++;
    if (actual !== expected)
      reportMismatch("evictLine", expected, actual);
  endtask

  function automatic int sizeBytes(input cachePkg::accessSize_e size);
    case (size)
      cachePkg::szByte: return 1;
      cachePkg::szHalf: return 2;
      default:          return 4;
    endcase
  endfunction

  function automatic logic [31:0] makeAddr(input int tagHigh, input int s, input int off);
    return (tagHigh << lowW) | (s << offW) | off;
  endfunction

  function automatic int randOffset(input cachePkg::accessSize_e size);
    return $urandom_range(`CACHE_LINE_BYTES - sizeBytes(size), 0);
  endfunction

  function automatic cachePkg::cacheLine_t randLine();
    cachePkg::cacheLine_t line;
    for (int i = 0; i < `CACHE_LINE_BYTES / 4; i++)
      line[i*32 +: 32] = $urandom;
    return line;
  endfunction

  // touched way goes to 0 and the more recent ways age by one
  task automatic touchWay(input int s, input int w);
    logic [`CACHE_LRU_W-1:0] oldPos;
    oldPos = modelTag[s][w].lru;
    for (int i = 0; i < `CACHE_WAYS; i++)
    begin
      if (i == w)
        modelTag[s][i].lru = '0;
      else if (modelTag[s][i].lru < oldPos)
        modelTag[s][i].lru = modelTag[s][i].lru + 1'b1;
    end
  endtask

  // drive one command on the falling edge and check its answer one cycle later
  task automatic runCmd(input cachePkg::cacheOp_e op, input logic [31:0] addr,
                        input cachePkg::accessSize_e size, input logic [31:0] data,
                        input cachePkg::cacheLine_t fill);
    cachePkg::cacheResp_t expResp;
    cachePkg::cacheLine_t expLine;
    logic                 lineKnown;
    int                   s;
    int                   off;
    int                   w;
    req      = '{op: op, addr: addr, size: size, writeData: data};
    fillLine = fill;
    @(posedge clk);
    @(negedge clk);
    s         = addr[offW +: `CACHE_INDEX_W];
    off       = addr[offW-1:0];
    w         = -1;
    expResp   = '0;
    expLine   = '0;
    lineKnown = 1'b1;
    case (op)
      cachePkg::opRead, cachePkg::opWrite:
      begin
        for (int i = 0; i < `CACHE_WAYS; i++)
          if (modelTag[s][i].valid && modelTag[s][i].tag == addr[`CACHE_ADDR_W-1:offW])
            w = i;
        if (w >= 0)
        begin
          expResp.hit = 1'b1;
          for (int b = 0; b < sizeBytes(size); b++)
          begin
            if (op == cachePkg::opRead)
              expResp.readData[b*8 +: 8] = modelLine[s][w][(off+b)*8 +: 8];
            else
              modelLine[s][w][(off+b)*8 +: 8] = data[b*8 +: 8];
          end
          if (op == cachePkg::opWrite)
            modelTag[s][w].dirty = 1'b1;
          touchWay(s, w);
        end
      end
      cachePkg::opInsert:
      begin
        for (int i = 0; i < `CACHE_WAYS; i++)
          if (modelTag[s][i].lru == '1)
            w = i;
        expResp.evictDirty = modelTag[s][w].valid && modelTag[s][w].dirty;
        expResp.evictAddr  = {modelTag[s][w].tag, {offW{1'b0}}};
        expLine            = modelLine[s][w];
        lineKnown          = modelTag[s][w].valid;   // never-filled way holds unknown data
        modelTag[s][w].tag   = addr[`CACHE_ADDR_W-1:offW];
        modelTag[s][w].valid = 1'b1;
        modelTag[s][w].dirty = 1'b0;
        modelLine[s][w]      = fill;
        touchWay(s, w);
      end
      cachePkg::opInit:
        for (int i = 0; i < `CACHE_WAYS; i++)
          modelTag[s][i] = '{tag: '0, lru: `CACHE_LRU_W'(i), valid: 1'b0, dirty: 1'b0};
      default:
        ;
    endcase
    checkResp(expResp, resp);
    if (lineKnown)
      checkLine(expLine, evictLine);
  endtask

  task automatic fillSet(input int s, input int base);
    runCmd(cachePkg::opInit, makeAddr(0, s, 0), cachePkg::szWord, '0, '0);
    for (int i = 0; i < `CACHE_WAYS; i++)
      runCmd(cachePkg::opInsert, makeAddr(base + i, s, 0), cachePkg::szWord, '0, randLine());
  endtask

  task automatic endTest(input string name, input int startErr);
    testsRun++;
    if (errors == startErr)
      $display("%s: passed", name);
    else
    begin
      testsFailed++;
      $display("%s: failed with %0d errors", name, errors - startErr);
    end
  endtask

  task automatic testIdle();
    int startErr;
    startErr = errors;
    for (int i = 0; i < 4; i++)
      runCmd(cachePkg::opIdle, $urandom, cachePkg::szWord, $urandom, randLine());
    endTest("idle after reset", startErr);
  endtask

  task automatic testReadHits();
    int                    startErr;
    int                    s;
    int                    base;
    cachePkg::accessSize_e sz;
    startErr = errors;
    s        = $urandom_range(`CACHE_SETS - 1, 0);
    base     = $urandom_range(4000, 1);
    fillSet(s, base);
    for (int k = 0; k < 12; k++)
    begin
      sz = cachePkg::accessSize_e'(k % 3);
      runCmd(cachePkg::opRead, makeAddr(base + $urandom_range(3, 0), s, randOffset(sz)),
             sz, '0, '0);
    end
    runCmd(cachePkg::opRead, makeAddr(base + 9, s, 0), cachePkg::szWord, '0, '0);  // miss
    endTest("insert and read", startErr);
  endtask

  task automatic testWrites();
    int                    startErr;
    int                    s;
    int                    base;
    logic [31:0]           a;
    cachePkg::accessSize_e sz;
    startErr = errors;
    s        = $urandom_range(`CACHE_SETS - 1, 0);
    base     = $urandom_range(4000, 1);
    fillSet(s, base);
    for (int k = 0; k < 6; k++)
    begin
      sz = cachePkg::accessSize_e'(k % 3);
      a  = makeAddr(base + $urandom_range(3, 0), s, randOffset(sz));
      runCmd(cachePkg::opWrite, a, sz, $urandom, '0);
      runCmd(cachePkg::opRead, a, sz, '0, '0);
    end
    runCmd(cachePkg::opWrite, makeAddr(base + 9, s, 0), cachePkg::szWord, $urandom, '0);
    // read every word of every way so stray byte writes show up
    for (int w = 0; w < `CACHE_WAYS; w++)
      for (int o = 0; o < `CACHE_LINE_BYTES; o += 4)
        runCmd(cachePkg::opRead, makeAddr(base + w, s, o), cachePkg::szWord, '0, '0);
    endTest("write merge", startErr);
  endtask

  task automatic testEviction();
    int startErr;
    int s;
    int base;
    int v;
    startErr = errors;
    s        = $urandom_range(`CACHE_SETS - 1, 0);
    base     = $urandom_range(4000, 1);
    v        = $urandom_range(3, 0);
    fillSet(s, base);
    runCmd(cachePkg::opWrite, makeAddr(base + v, s, 0), cachePkg::szWord, $urandom, '0);
    for (int i = 0; i < `CACHE_WAYS; i++)
      if (i != v)
        runCmd(cachePkg::opRead, makeAddr(base + i, s, 4 * i), cachePkg::szWord, '0, '0);
    // written way is now oldest and dirty
    runCmd(cachePkg::opInsert, makeAddr(base + 4, s, 0), cachePkg::szWord, '0, randLine());
    runCmd(cachePkg::opRead, makeAddr(base + 4, s, 8), cachePkg::szWord, '0, '0);
    runCmd(cachePkg::opRead, makeAddr(base + v, s, 0), cachePkg::szWord, '0, '0);
    runCmd(cachePkg::opInsert, makeAddr(base + 5, s, 0), cachePkg::szWord, '0, randLine());
    endTest("LRU eviction", startErr);
  endtask

  task automatic testForwarding();
    int          startErr;
    int          s;
    int          base;
    logic [31:0] a;
    startErr = errors;
    s        = $urandom_range(`CACHE_SETS - 1, 0);
    base     = $urandom_range(4000, 1);
    runCmd(cachePkg::opInit, makeAddr(0, s, 0), cachePkg::szWord, '0, '0);
    runCmd(cachePkg::opInsert, makeAddr(base, s, 0), cachePkg::szWord, '0, randLine());
    runCmd(cachePkg::opRead, makeAddr(base, s, 20), cachePkg::szWord, '0, '0);
    a = makeAddr(base, s, 33);
    runCmd(cachePkg::opWrite, a, cachePkg::szByte, $urandom, '0);
    runCmd(cachePkg::opRead, a, cachePkg::szByte, '0, '0);
    a = makeAddr(base, s, 32);
    runCmd(cachePkg::opWrite, a, cachePkg::szHalf, $urandom, '0);
    runCmd(cachePkg::opRead, a, cachePkg::szWord, '0, '0);
    for (int i = 1; i < `CACHE_WAYS; i++)
      runCmd(cachePkg::opInsert, makeAddr(base + i, s, 0), cachePkg::szWord, '0, randLine());
    runCmd(cachePkg::opInsert, makeAddr(base + 4, s, 0), cachePkg::szWord, '0, randLine());
    runCmd(cachePkg::opRead, makeAddr(base + 4, s, 60), cachePkg::szWord, '0, '0);
    endTest("back-to-back forwarding", startErr);
  endtask

  initial
  begin
    int   waitCount;
    logic resetLost;
    void'($urandom(61381));
    req       = '{op: cachePkg::opIdle, addr: '0, size: cachePkg::szByte, writeData: '0};
    fillLine  = '0;
    waitCount = 0;
    while (rstN !== 1'b1 && waitCount < resetLimit)
    begin
      @(negedge clk);
      waitCount++;
    end
    resetLost = (rstN !== 1'b1);
    if (resetLost)
      $display("reset was not released within %0d cycles", resetLimit);
    else
    begin
      testIdle();
      testReadHits();
      testWrites();
      testEviction();
      testForwarding();
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checks, errors);
    if (errors == 0 && !resetLost)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== bench/clockGen.sv ====
module clockGen (
  output logic clk,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  // low across two rising edges, released on a falling edge
  initial
  begin
    rstN = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN <= 1'b1;
  end

endmodule

// ==== src/byteMerge.sv ====
`include "cacheSettings.svh"

module byteMerge (
  input  cachePkg::cacheLine_t          line,
  input  logic [`CACHE_OFFSET_W-1:0]    offset,
  input  cachePkg::accessSize_e         size,
  input  logic [`CACHE_WORD_W-1:0]      writeData,
  output cachePkg::cacheLine_t          merged
);

  logic [3:0]                   sizeMask;
  logic [`CACHE_LINE_BYTES-1:0] byteEn;
  cachePkg::cacheLine_t         shifted;

  // byte enables of the access before it is moved to its offset
  always_comb
  begin
    case (size)
      cachePkg::szByte: sizeMask = 4'b0001;
      cachePkg::szHalf: sizeMask = 4'b0011;
      default:          sizeMask = 4'b1111;
    endcase
  end

  // enables and data move together, one byte per offset step
  assign byteEn  = `CACHE_LINE_BYTES'(sizeMask) << offset;
  assign shifted = cachePkg::cacheLine_t'(writeData) << {offset, 3'b000};

  always_comb
  begin
    for (int b = 0; b < `CACHE_LINE_BYTES; b++)
    begin
      if (byteEn[b])
        merged[b*8 +: 8] = shifted[b*8 +: 8];
      else
        merged[b*8 +: 8] = line[b*8 +: 8];      // untouched byte
    end
  end

endmodule

// ==== src/byteSelect.sv ====
`include "cacheSettings.svh"

module byteSelect (
  input  cachePkg::cacheLine_t          line,
  input  logic [`CACHE_OFFSET_W-1:0]    offset,
  input  cachePkg::accessSize_e         size,
  output logic [`CACHE_WORD_W-1:0]      value
);

  // each stage keeps 4 extra bytes so an access may straddle a boundary
  logic [543:0] padded;
  logic [287:0] sel32;
  logic [159:0] sel16;
  logic [95:0]  sel8;
  logic [63:0]  sel4;
  logic [47:0]  sel2;
  logic [39:0]  sel1;

  assign padded = {32'b0, line};   // bytes past the line end read as zero
  assign sel32  = offset[5] ? padded[543:256] : padded[287:0];
  assign sel16  = offset[4] ? sel32[287:128] : sel32[159:0];
  assign sel8   = offset[3] ? sel16[159:64] : sel16[95:0];
  assign sel4   = offset[2] ? sel8[95:32] : sel8[63:0];
  assign sel2   = offset[1] ? sel4[63:16] : sel4[47:0];
  assign sel1   = offset[0] ? sel2[47:8] : sel2[39:0];

  always_comb
  begin
    case (size)
      cachePkg::szByte: value = {24'b0, sel1[7:0]};
      cachePkg::szHalf: value = {16'b0, sel1[15:0]};
      default:          value = sel1[31:0];
    endcase
  end

endmodule

// ==== src/cachePkg.sv ====
`include "cacheSettings.svh"

package cachePkg;

  typedef enum logic [2:0]
  {
    opIdle,
    opRead,
    opWrite,
    opInsert,
    opInit
  } cacheOp_e;

  typedef enum logic [1:0]
  {
    szByte,
    szHalf,
    szWord
  } accessSize_e;

  typedef logic [`CACHE_LINE_BYTES*8-1:0] cacheLine_t;

  // one way of a set, 30 bits
  typedef struct packed
  {
    logic [`CACHE_TAG_W-1:0] tag;
    logic [`CACHE_LRU_W-1:0] lru;
    logic valid;
    logic dirty;
  } wayTag_t;

  typedef wayTag_t [`CACHE_WAYS-1:0] tagSet_t;   // whole tag memory word

  typedef logic [`CACHE_WAYS-1:0] wayMask_t;

  typedef struct packed
  {
    cacheOp_e op;
    logic [`CACHE_ADDR_W-1:0] addr;
    accessSize_e size;
    logic [`CACHE_WORD_W-1:0] writeData;
  } cacheReq_t;

  typedef struct packed
  {
    logic hit;
    logic [`CACHE_WORD_W-1:0] readData;
    logic evictDirty;                      // only meaningful on insert
    logic [`CACHE_ADDR_W-1:0] evictAddr;
  } cacheResp_t;

endpackage

// ==== src/cacheSettings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// byte address presented with each command
`define CACHE_ADDR_W 32

// geometry of the four-way data cache
`define CACHE_SETS 64
`define CACHE_WAYS 4
`define CACHE_LINE_BYTES 64

// width of a read result and of write data
`define CACHE_WORD_W 32

// address split: tag | index | offset
`define CACHE_OFFSET_W 6
`define CACHE_INDEX_W 6
`define CACHE_TAG_W 26

// LRU position per way, 0 is most recent
`define CACHE_LRU_W 2

`endif

// ==== src/dataCache.sv ====
`include "cacheSettings.svh"

module dataCache (
  input  logic                  clk,
  input  logic                  rstN,
  input  cachePkg::cacheReq_t   req,
  input  cachePkg::cacheLine_t  fillLine,
  output cachePkg::cacheResp_t  resp,
  output cachePkg::cacheLine_t  evictLine
);

  cachePkg::cacheReq_t                      reqQ;
  cachePkg::cacheLine_t                     fillQ;
  logic [`CACHE_INDEX_W-1:0]                readIndex;
  logic [`CACHE_INDEX_W-1:0]                writeIndex;
  cachePkg::tagSet_t                        tagSet;
  cachePkg::tagSet_t                        newTagSet;
  logic                                     tagWe;
  cachePkg::wayMask_t                       hitWays;
  cachePkg::wayMask_t                       wayWe;
  cachePkg::wayMask_t                       selWays;
  cachePkg::cacheLine_t [`CACHE_WAYS-1:0]   wayLine;
  cachePkg::cacheLine_t [`CACHE_WAYS-1:0]   wayData;
  cachePkg::cacheLine_t                     selLine;
  cachePkg::cacheLine_t                     mergedLine;
  logic [`CACHE_WORD_W-1:0]                 selValue;
  logic                                     tagHit;
  logic                                     evictDirty;
  logic [`CACHE_ADDR_W-1:0]                 evictAddr;
  logic                                     isInsert;

  always_ff @(posedge clk)
  begin
    reqQ  <= req;
    fillQ <= fillLine;
    if (!rstN)
      reqQ.op <= cachePkg::opIdle;
  end

  assign readIndex  = req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];    // incoming command
  assign writeIndex = reqQ.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];   // resolving command
  assign isInsert   = (reqQ.op == cachePkg::opInsert);

  lineRam #(.dataW($bits(cachePkg::tagSet_t))) tagMem (
    .clk        (clk),
    .we         (tagWe),
    .readIndex  (readIndex),
    .writeIndex (writeIndex),
    .readData   (tagSet),
    .writeData  (newTagSet)
  );

  tagControl tagControl0 (
    .clk        (clk),
    .rstN       (rstN),
    .op         (reqQ.op),
    .addr       (reqQ.addr),
    .tagSet     (tagSet),
    .tagWe      (tagWe),
    .newTagSet  (newTagSet),
    .hitWays    (hitWays),
    .wayWe      (wayWe),
    .hit        (tagHit),
    .evictDirty (evictDirty),
    .evictAddr  (evictAddr)
  );

  for (genvar w = 0; w < `CACHE_WAYS; w++)
  begin : genWay
    assign wayData[w] = isInsert ? fillQ : mergedLine;
    lineRam #(.dataW($bits(cachePkg::cacheLine_t))) wayMem (
      .clk        (clk),
      .we         (wayWe[w]),
      .readIndex  (readIndex),
      .writeIndex (writeIndex),
      .readData   (wayLine[w]),
      .writeData  (wayData[w])
    );
  end

  // on insert wayWe marks the victim, otherwise follow the hit
  assign selWays = isInsert ? wayWe : hitWays;

  always_comb
  begin
    selLine = '0;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      if (selWays[w])
        selLine = selLine | wayLine[w];
    end
  end

  byteSelect byteSelect0 (
    .line   (selLine),
    .offset (reqQ.addr[`CACHE_OFFSET_W-1:0]),
    .size   (reqQ.size),
    .value  (selValue)
  );

  byteMerge byteMerge0 (
    .line      (selLine),
    .offset    (reqQ.addr[`CACHE_OFFSET_W-1:0]),
    .size      (reqQ.size),
    .writeData (reqQ.writeData),
    .merged    (mergedLine)
  );

  assign resp = '{
    hit:        tagHit,
    readData:   (reqQ.op == cachePkg::opRead && tagHit) ? selValue : '0,
    evictDirty: evictDirty,
    evictAddr:  evictAddr
  };
  assign evictLine = isInsert ? selLine : '0;

  // a write must end inside its own line, the merge drops anything beyond
  writeInLine: assert property (@(posedge clk) disable iff (!rstN)
    (reqQ.op == cachePkg::opWrite) |->
    ((7'(reqQ.addr[`CACHE_OFFSET_W-1:0]) + (7'd1 << reqQ.size)) <= 7'(`CACHE_LINE_BYTES)));

endmodule

// ==== src/lineRam.sv ====
`include "cacheSettings.svh"

module lineRam #(
  parameter int dataW = 512
) (
  input  logic                      clk,
  input  logic                      we,
  input  logic [`CACHE_INDEX_W-1:0] readIndex,
  input  logic [`CACHE_INDEX_W-1:0] writeIndex,
  output logic [dataW-1:0]          readData,
  input  logic [dataW-1:0]          writeData
);

  logic [dataW-1:0] mem [`CACHE_SETS];
  logic [dataW-1:0] memData;
  logic [dataW-1:0] fwdData;
  logic             fwd;

  // array read sees the old entry when both ports hit the same set
  always_ff @(posedge clk)
  begin
    memData <= mem[readIndex];
    if (we)
    begin
      mem[writeIndex] <= writeData;
    end
  end

  // remember the collision so the next cycle returns the new contents
  always_ff @(posedge clk)
  begin
    fwd     <= we && (writeIndex == readIndex);
    fwdData <= writeData;
  end

  assign readData = fwd ? fwdData : memData;

endmodule

// ==== src/lruUpdate.sv ====
`include "cacheSettings.svh"

module lruUpdate (
  input  cachePkg::tagSet_t                              oldSet,
  input  cachePkg::wayMask_t                             touched,
  output logic [`CACHE_WAYS-1:0][`CACHE_LRU_W-1:0]       newLru
);

  logic [`CACHE_LRU_W-1:0] touchedPos;

  // old position of the touched way, at most one bit of touched is set
  always_comb
  begin
    touchedPos = '0;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      if (touched[w])
        touchedPos = oldSet[w].lru;
    end
  end

  always_comb
  begin
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      if (touched == '0)
        newLru[w] = oldSet[w].lru;                  // nothing touched
      else if (touched[w])
        newLru[w] = '0;
      else if (oldSet[w].lru < touchedPos)
        newLru[w] = oldSet[w].lru + 1'b1;           // ages by one
      else
        newLru[w] = oldSet[w].lru;
    end
  end

endmodule

// ==== src/tagControl.sv ====
`include "cacheSettings.svh"

module tagControl (
  input  logic                        clk,
  input  logic                        rstN,
  input  cachePkg::cacheOp_e          op,
  input  logic [`CACHE_ADDR_W-1:0]    addr,
  input  cachePkg::tagSet_t           tagSet,
  output logic                        tagWe,
  output cachePkg::tagSet_t           newTagSet,
  output cachePkg::wayMask_t          hitWays,
  output cachePkg::wayMask_t          wayWe,
  output logic                        hit,
  output logic                        evictDirty,
  output logic [`CACHE_ADDR_W-1:0]    evictAddr
);

  logic [`CACHE_TAG_W-1:0]                  addrTag;
  logic                                     isAccess;
  cachePkg::wayMask_t                       tagMatch;
  cachePkg::wayMask_t                       lruWay;
  cachePkg::wayMask_t                       touched;
  logic [`CACHE_WAYS-1:0][`CACHE_LRU_W-1:0] newLru;
  logic [`CACHE_TAG_W-1:0]                  victimTag;
  logic                                     victimDirty;

  assign addrTag  = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign isAccess = (op == cachePkg::opRead) || (op == cachePkg::opWrite);

  always_comb
  begin
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      tagMatch[w] = tagSet[w].valid && (tagSet[w].tag == addrTag);
      lruWay[w]   = (tagSet[w].lru == '1);     // oldest way is the victim
    end
  end

  assign hitWays = isAccess ? tagMatch : '0;
  assign touched = isAccess ? tagMatch : ((op == cachePkg::opInsert) ? lruWay : '0);

  lruUpdate lruUpdate0 (
    .oldSet  (tagSet),
    .touched (touched),
    .newLru  (newLru)
  );

  always_comb
  begin
    newTagSet = tagSet;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      newTagSet[w].lru = newLru[w];
      case (op)
        cachePkg::opWrite:
        begin
          if (tagMatch[w])
            newTagSet[w].dirty = 1'b1;
        end
        cachePkg::opInsert:
        begin
          if (lruWay[w])
          begin
            newTagSet[w].tag   = addrTag;
            newTagSet[w].valid = 1'b1;
            newTagSet[w].dirty = 1'b0;
          end
        end
        cachePkg::opInit:
          newTagSet[w] = '{tag: '0, lru: `CACHE_LRU_W'(w), valid: 1'b0, dirty: 1'b0};
        default:
          ;
      endcase
    end
  end

  // a read rewrites the set too, that is how its LRU change lands
  assign tagWe = (op != cachePkg::opIdle);

  always_comb
  begin
    case (op)
      cachePkg::opWrite:  wayWe = tagMatch;
      cachePkg::opInsert: wayWe = lruWay;
      default:            wayWe = '0;
    endcase
  end

  always_comb
  begin
    victimTag   = '0;
    victimDirty = 1'b0;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      if (lruWay[w])
      begin
        victimTag   = victimTag | tagSet[w].tag;
        victimDirty = victimDirty | (tagSet[w].valid && tagSet[w].dirty);
      end
    end
  end

  assign hit        = isAccess && (tagMatch != '0);
  assign evictDirty = (op == cachePkg::opInsert) && victimDirty;
  assign evictAddr  = (op == cachePkg::opInsert) ?
                      {victimTag, {`CACHE_OFFSET_W{1'b0}}} : '0;

  // inserts never leave two valid copies of one tag in a set
  hitOneHot: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0(hitWays));

  // init and every LRU update keep the positions a permutation
  victimUnique: assert property (@(posedge clk) disable iff (!rstN)
    (op == cachePkg::opInsert) |-> $onehot(lruWay));

endmodule

// ==== verilog.f ====
+incdir+src
src/cachePkg.sv
src/lineRam.sv
src/lruUpdate.sv
src/byteSelect.sv
src/byteMerge.sv
src/tagControl.sv
src/dataCache.sv
bench/clockGen.sv
bench/cacheTb.sv
